//--- src/vid_pkg.sv
// shared constants and types for the small video display controller
// raster sizes, bus register numbers, colour formats and config structs
// every design unit refers to these by scoped name
package vid_pkg;

    // raster geometry, tiny so a full frame simulates in a few hundred cycles
    localparam int H_VISIBLE    = 16;       // visible pixels per line
    localparam int H_TOTAL      = 24;       // pixels per line incl. blanking
    localparam int H_SYNC_START = 18;       // first hsync pixel
    localparam int H_SYNC_END   = 21;       // first pixel after hsync
    localparam int V_VISIBLE    = 8;        // visible lines per frame
    localparam int V_TOTAL      = 12;       // lines per frame
    localparam int V_SYNC_START = 9;        // first vsync line
    localparam int V_SYNC_END   = 10;       // first line after vsync

    typedef logic [4:0] hcount_t;           // column, 0..H_TOTAL-1
    typedef logic [3:0] vcount_t;           // line, 0..V_TOTAL-1

    // 4:4:4 colour, red in the top nibble
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    typedef struct packed {
        logic [3:0] alpha;                  // 0 = transparent
        rgb_t       rgb;
    } argb_t;

    // per playfield settings, CTRL and COLOR registers
    typedef struct packed {
        logic       enable;
        logic [1:0] tile_log2;              // tile edge is 1 << tile_log2 pixels
        logic [3:0] alpha;
        rgb_t       colour;
    } pf_cfg_t;

    typedef enum logic {
        BLEND_OVERLAY  = 1'b0,              // B over A where B alpha non-zero
        BLEND_ADDCLAMP = 1'b1               // per channel A+B, saturating
    } blend_mode_t;

    typedef struct packed {
        pf_cfg_t     pfa;
        pf_cfg_t     pfb;
        blend_mode_t mode;
    } vid_cfg_t;

    // beam position and derived raster flags
    typedef struct packed {
        hcount_t h;
        vcount_t v;
        logic    visible;                   // inside active area
        logic    hsync;
        logic    vsync;
        logic    h_blank;                   // right of active area
        logic    v_blank;                   // below active area
    } beam_t;

    // bus register numbers
    localparam logic [3:0] REG_PFA_COLOR = 4'h0;
    localparam logic [3:0] REG_PFA_CTRL  = 4'h1;
    localparam logic [3:0] REG_PFB_COLOR = 4'h2;
    localparam logic [3:0] REG_PFB_CTRL  = 4'h3;
    localparam logic [3:0] REG_BLEND     = 4'h4;
    localparam logic [3:0] REG_INT_CTRL  = 4'h5;   // lo = pending/clear, hi = mask
    localparam logic [3:0] REG_STATUS    = 4'h6;   // read only

    localparam int INTR_VBLANK = 0;         // pending/mask bit for vblank

endpackage

//--- src/vid_timing.sv
// raster timing generator
// free-running column and line counters, one pixel per clock
// beam_o carries position plus visible, sync and blank flags, all registered
module vid_timing (
    input  wire logic       clk,
    input  wire logic       reset_i,
    output vid_pkg::beam_t  beam_o
);

    vid_pkg::hcount_t h_next;           // column for next cycle
    vid_pkg::vcount_t v_next;           // line for next cycle
    logic             h_last;           // last column of line
    logic             v_last;           // last line of frame

    assign h_last = (beam_o.h == vid_pkg::hcount_t'(vid_pkg::H_TOTAL - 1));
    assign v_last = (beam_o.v == vid_pkg::vcount_t'(vid_pkg::V_TOTAL - 1));

    // next position, line advances on column wrap
    always_comb begin
        h_next = beam_o.h + 1'b1;
        v_next = beam_o.v;
        if (h_last) begin
            h_next = '0;
            v_next = v_last ? '0 : beam_o.v + 1'b1;
        end
    end

    // flags are computed from the next position so they stay in step with h/v
    always_ff @(posedge clk) begin
        if (reset_i) begin
            beam_o <= '0;                   // all flags low, beam at origin
        end else begin
            beam_o.h       <= h_next;
            beam_o.v       <= v_next;
            beam_o.h_blank <= (h_next >= vid_pkg::hcount_t'(vid_pkg::H_VISIBLE));
            beam_o.v_blank <= (v_next >= vid_pkg::vcount_t'(vid_pkg::V_VISIBLE));
            beam_o.visible <= (h_next < vid_pkg::hcount_t'(vid_pkg::H_VISIBLE))
                           && (v_next < vid_pkg::vcount_t'(vid_pkg::V_VISIBLE));
            // sync windows are half-open, start <= n < end
            beam_o.hsync   <= (h_next >= vid_pkg::hcount_t'(vid_pkg::H_SYNC_START))
                           && (h_next < vid_pkg::hcount_t'(vid_pkg::H_SYNC_END));
            beam_o.vsync   <= (v_next >= vid_pkg::vcount_t'(vid_pkg::V_SYNC_START))
                           && (v_next < vid_pkg::vcount_t'(vid_pkg::V_SYNC_END));
        end
    end

endmodule

//--- src/playfield_gen.sv
// checkerboard playfield
// draws solid tiles in the configured colour and alpha, tile size 1..8 px
// output pixel is registered, one cycle behind the beam that made it
module playfield_gen (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  vid_pkg::pf_cfg_t    cfg_i,
    input  vid_pkg::beam_t      beam_i,
    output vid_pkg::argb_t      pixel_o
);

    logic tile_bit;                     // checker parity at this position
    logic pix_on;                       // draw this pixel

    // tile_log2 picks which counter bit flips the pattern
    assign tile_bit = beam_i.h[cfg_i.tile_log2] ^ beam_i.v[cfg_i.tile_log2];
    assign pix_on   = tile_bit & cfg_i.enable & beam_i.visible;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pixel_o <= '0;
        end else if (pix_on) begin
            pixel_o.alpha <= cfg_i.alpha;
            pixel_o.rgb   <= cfg_i.colour;
        end else begin
            pixel_o <= '0;                  // transparent black
        end
    end

endmodule

//--- src/pf_blend.sv
// playfield blender and video output stage
// combines playfield A and B pixels by overlay or clamped add
// sync and display enable are delayed to match the pixel pipeline, so all
// outputs land two cycles after the beam; rgb is forced black outside de
module pf_blend (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  vid_pkg::blend_mode_t    mode_i,
    input  vid_pkg::beam_t          beam_i,
    input  vid_pkg::argb_t          pixel_a_i,
    input  vid_pkg::argb_t          pixel_b_i,
    output vid_pkg::rgb_t           rgb_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    dv_de_o
);

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } sync_t;

    sync_t          sync_q;             // video timing, aligned to pf pixels
    vid_pkg::rgb_t  blend_rgb;          // combined colour before de gating

    // one channel add, saturating at 15
    function automatic logic [3:0] sat_add(input logic [3:0] a, input logic [3:0] b);
        logic [4:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[4] ? 4'hF : sum[3:0];
    endfunction

    always_comb begin
        case (mode_i)
            vid_pkg::BLEND_ADDCLAMP: begin
                blend_rgb.red   = sat_add(pixel_a_i.rgb.red,   pixel_b_i.rgb.red);
                blend_rgb.green = sat_add(pixel_a_i.rgb.green, pixel_b_i.rgb.green);
                blend_rgb.blue  = sat_add(pixel_a_i.rgb.blue,  pixel_b_i.rgb.blue);
            end
            default: begin
                // overlay, any non-zero B alpha covers A
                blend_rgb = (pixel_b_i.alpha != 4'h0) ? pixel_b_i.rgb : pixel_a_i.rgb;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sync_q  <= '0;
            rgb_o   <= '0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            dv_de_o <= 1'b0;
        end else begin
            sync_q.hsync <= beam_i.hsync;           // stage 1, beside pf regs
            sync_q.vsync <= beam_i.vsync;
            sync_q.de    <= beam_i.visible;
            hsync_o      <= sync_q.hsync;           // stage 2, output regs
            vsync_o      <= sync_q.vsync;
            dv_de_o      <= sync_q.de;
            rgb_o        <= sync_q.de ? blend_rgb : '0;    // black in blanking
        end
    end

endmodule

//--- src/bus_regs.sv
// CPU register interface
// 8-bit bus with active low select, byte select picks even/odd half of a
// 16-bit register; an access starts on the first cycle select is seen low
// holds playfield and blend config, interrupt mask and pending state,
// and pulses bus_intr_o when an unmasked interrupt becomes pending
module bus_regs (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,         // select, active low
    input  wire logic           bus_rd_nwr_i,       // 1 = read, 0 = write
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,      // 0 = even byte, 1 = odd
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    input  vid_pkg::beam_t      beam_i,
    output vid_pkg::vid_cfg_t   cfg_o,
    output logic                bus_intr_o
);

    logic        cs_n_q;                // select from last cycle
    logic        bus_start;             // first low cycle of select
    logic        wr_strobe;
    logic        v_blank_q;
    logic        vblank_rise;
    logic [3:0]  intr_mask;             // INT_CTRL high byte
    logic [3:0]  intr_pending;          // INT_CTRL low byte
    logic [3:0]  intr_signal;           // new interrupt events this cycle
    logic [3:0]  intr_clear;            // CPU clear strobe
    logic [15:0] rd_word;               // selected register, both bytes

    assign bus_start   = cs_n_q & ~bus_cs_n_i;
    assign wr_strobe   = bus_start & ~bus_rd_nwr_i;
    assign vblank_rise = beam_i.v_blank & ~v_blank_q;

    always_comb begin
        intr_signal = '0;
        intr_signal[vid_pkg::INTR_VBLANK] = vblank_rise;
    end

    // a write of ones to INT_CTRL low byte acknowledges those bits
    assign intr_clear = (wr_strobe && !bus_bytesel_i && bus_reg_num_i == vid_pkg::REG_INT_CTRL)
                      ? bus_data_i[3:0] : 4'h0;

    // byte write into one playfield's COLOR or CTRL register
    function automatic vid_pkg::pf_cfg_t pf_write(input vid_pkg::pf_cfg_t cur,
                                                  input logic ctrl, input logic odd,
                                                  input logic [7:0] d);
        vid_pkg::pf_cfg_t nxt;
        nxt = cur;
        if (ctrl) begin
            if (!odd) begin             // CTRL high byte unused
                nxt.enable    = d[0];
                nxt.tile_log2 = d[2:1];
                nxt.alpha     = d[7:4];
            end
        end else if (odd) begin
            nxt.colour.red = d[3:0];
        end else begin
            nxt.colour.green = d[7:4];
            nxt.colour.blue  = d[3:0];
        end
        return nxt;
    endfunction

    // read-back mux, unused bits and registers read zero
    always_comb begin
        case (bus_reg_num_i)
            vid_pkg::REG_PFA_COLOR: rd_word = {4'h0, cfg_o.pfa.colour};
            vid_pkg::REG_PFA_CTRL:  rd_word = {8'h00, cfg_o.pfa.alpha, 1'b0,
                                               cfg_o.pfa.tile_log2, cfg_o.pfa.enable};
            vid_pkg::REG_PFB_COLOR: rd_word = {4'h0, cfg_o.pfb.colour};
            vid_pkg::REG_PFB_CTRL:  rd_word = {8'h00, cfg_o.pfb.alpha, 1'b0,
                                               cfg_o.pfb.tile_log2, cfg_o.pfb.enable};
            vid_pkg::REG_BLEND:     rd_word = {15'h0000, cfg_o.mode};
            vid_pkg::REG_INT_CTRL:  rd_word = {4'h0, intr_mask, 4'h0, intr_pending};
            vid_pkg::REG_STATUS:    rd_word = {8'h00, intr_pending, 2'b00,
                                               beam_i.v_blank, beam_i.h_blank};
            default:                rd_word = 16'h0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_n_q       <= 1'b1;
            v_blank_q    <= 1'b0;
            cfg_o        <= '0;             // both playfields off, overlay
            intr_mask    <= '0;
            intr_pending <= '0;
            bus_intr_o   <= 1'b0;
            bus_data_o   <= '0;
        end else begin
            cs_n_q    <= bus_cs_n_i;
            v_blank_q <= beam_i.v_blank;
            if (wr_strobe) begin
                case (bus_reg_num_i)
                    vid_pkg::REG_PFA_COLOR, vid_pkg::REG_PFA_CTRL: begin
                        cfg_o.pfa <= pf_write(cfg_o.pfa, bus_reg_num_i == vid_pkg::REG_PFA_CTRL,
                                              bus_bytesel_i, bus_data_i);
                    end
                    vid_pkg::REG_PFB_COLOR, vid_pkg::REG_PFB_CTRL: begin
                        cfg_o.pfb <= pf_write(cfg_o.pfb, bus_reg_num_i == vid_pkg::REG_PFB_CTRL,
                                              bus_bytesel_i, bus_data_i);
                    end
                    vid_pkg::REG_BLEND: begin
                        if (!bus_bytesel_i) cfg_o.mode <= vid_pkg::blend_mode_t'(bus_data_i[0]);
                    end
                    vid_pkg::REG_INT_CTRL: begin
                        if (bus_bytesel_i) intr_mask <= bus_data_i[3:0];
                    end
                    default: ;                  // STATUS and unused ignore writes
                endcase
            end
            if (bus_start && bus_rd_nwr_i) begin
                bus_data_o <= bus_bytesel_i ? rd_word[15:8] : rd_word[7:0];  // held till next read
            end
            // strobe only on a newly pending, unmasked source
            bus_intr_o   <= |(intr_signal & intr_mask & ~intr_pending);
            intr_pending <= (intr_pending | intr_signal) & ~intr_clear;
        end
    end

endmodule

//--- src/vid_main.sv
// top level of the video display controller
// CPU register block, raster timing, two checkerboard playfields and the
// blender; video outputs trail the beam by two clocks
module vid_main (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,         // register select, active low
    input  wire logic           bus_rd_nwr_i,       // 1 = read, 0 = write
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,      // 0 = even byte, 1 = odd
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    output logic                bus_intr_o,         // vblank interrupt strobe
    output vid_pkg::rgb_t       rgb_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o             // display enable
);

    vid_pkg::vid_cfg_t  cfg;            // live configuration from registers
    vid_pkg::beam_t     beam;           // raster position and flags
    vid_pkg::argb_t     pixel_a;        // pf A, one cycle after beam
    vid_pkg::argb_t     pixel_b;        // pf B, one cycle after beam

    bus_regs regs0 (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o),
        .beam_i        (beam),              // blank status, vblank irq
        .cfg_o         (cfg),
        .bus_intr_o    (bus_intr_o)
    );

    vid_timing timing0 (
        .clk     (clk),
        .reset_i (reset_i),
        .beam_o  (beam)
    );

    playfield_gen pf_a (
        .clk     (clk),
        .reset_i (reset_i),
        .cfg_i   (cfg.pfa),
        .beam_i  (beam),
        .pixel_o (pixel_a)
    );

    playfield_gen pf_b (
        .clk     (clk),
        .reset_i (reset_i),
        .cfg_i   (cfg.pfb),
        .beam_i  (beam),
        .pixel_o (pixel_b)
    );

    pf_blend blend0 (
        .clk       (clk),
        .reset_i   (reset_i),
        .mode_i    (cfg.mode),
        .beam_i    (beam),                  // syncs and visible only
        .pixel_a_i (pixel_a),
        .pixel_b_i (pixel_b),
        .rgb_o     (rgb_o),
        .hsync_o   (hsync_o),
        .vsync_o   (vsync_o),
        .dv_de_o   (dv_de_o)
    );

endmodule

//--- test/vid_main_assertions.sv
// bound checker for the video display controller
// keeps its own two-stage pixel model, a sync delay line and a model of
// the vblank interrupt and mask, all worked out from cfg, beam and the bus
// attached to vid_main by the bind at the bottom of this file
module vid_main_assertions (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  vid_pkg::vid_cfg_t   cfg_i,
    input  vid_pkg::beam_t      beam_i,
    input  vid_pkg::argb_t      pixel_a_i,
    input  vid_pkg::argb_t      pixel_b_i,
    input  wire logic           bus_cs_n_i,
    input  wire logic           bus_rd_nwr_i,
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,
    input  wire logic [7:0]     bus_data_i,
    input  wire logic [7:0]     bus_rdata_i,        // bus_data_o of the DUT
    input  wire logic           intr_i,
    input  vid_pkg::rgb_t       rgb_i,
    input  wire logic           hsync_i,
    input  wire logic           vsync_i,
    input  wire logic           de_i
);

    int              fail_cnt = 0;      // polled by the testbench top
    vid_pkg::argb_t  exp_a;             // stage 1, playfield A
    vid_pkg::argb_t  exp_b;             // stage 1, playfield B
    vid_pkg::rgb_t   exp_rgb;           // stage 2, output colour
    logic [2:0]      sync1;             // {hsync, vsync, de} stage 1
    logic [2:0]      sync2;             // same, stage 2
    logic            cs_q;
    logic            acc;               // first low select cycle
    logic            vb_q;
    logic            vb_rise;
    logic            mask;              // vblank mask bit
    logic            pend;              // vblank pending bit
    logic            exp_intr;
    logic            status_chk;        // STATUS even byte read last cycle
    logic [7:0]      exp_status;

    // flags from the raster rules, {visible, hsync, vsync, h_blank, v_blank}
    function automatic logic [4:0] raster_flags(input int h, input int v);
        logic vis;
        logic hs;
        logic vs;
        vis = (h < vid_pkg::H_VISIBLE) && (v < vid_pkg::V_VISIBLE);
        hs  = (h >= vid_pkg::H_SYNC_START) && (h < vid_pkg::H_SYNC_END);
        vs  = (v >= vid_pkg::V_SYNC_START) && (v < vid_pkg::V_SYNC_END);
        return {vis, hs, vs, h >= vid_pkg::H_VISIBLE, v >= vid_pkg::V_VISIBLE};
    endfunction

    // checker tile lit when tile column plus tile row is odd
    function automatic vid_pkg::argb_t pf_expect(input vid_pkg::pf_cfg_t c,
                                                 input vid_pkg::beam_t b);
        int tile;
        tile = 1 << c.tile_log2;
        if (c.enable && b.visible && ((int'(b.h) / tile + int'(b.v) / tile) % 2 == 1))
            return {c.alpha, c.colour};
        return '0;                          // transparent black
    endfunction

    function automatic logic [3:0] chan_sum(input logic [3:0] x, input logic [3:0] y);
        int s;
        s = int'(x) + int'(y);
        return (s > 15) ? 4'hF : 4'(s);
    endfunction

    function automatic vid_pkg::rgb_t blend_expect(input vid_pkg::blend_mode_t m,
                                                   input vid_pkg::argb_t a,
                                                   input vid_pkg::argb_t b);
        vid_pkg::rgb_t r;
        if (m == vid_pkg::BLEND_OVERLAY)
            return (b.alpha != 4'h0) ? b.rgb : a.rgb;
        r.red   = chan_sum(a.rgb.red, b.rgb.red);
        r.green = chan_sum(a.rgb.green, b.rgb.green);
        r.blue  = chan_sum(a.rgb.blue, b.rgb.blue);
        return r;
    endfunction

    assign acc     = cs_q & ~bus_cs_n_i;
    assign vb_rise = (beam_i.v >= vid_pkg::V_VISIBLE) & ~vb_q;     // entering vblank

    always_ff @(posedge clk) begin
        if (reset_i) begin
            exp_a      <= '0;
            exp_b      <= '0;
            exp_rgb    <= '0;
            sync1      <= '0;
            sync2      <= '0;
            cs_q       <= 1'b1;
            vb_q       <= 1'b0;
            mask       <= 1'b0;
            pend       <= 1'b0;
            exp_intr   <= 1'b0;
            status_chk <= 1'b0;
            exp_status <= '0;
        end else begin
            exp_a   <= pf_expect(cfg_i.pfa, beam_i);
            exp_b   <= pf_expect(cfg_i.pfb, beam_i);
            sync1   <= {beam_i.hsync, beam_i.vsync, beam_i.visible};
            sync2   <= sync1;
            exp_rgb <= sync1[0] ? blend_expect(cfg_i.mode, exp_a, exp_b) : '0;
            cs_q    <= bus_cs_n_i;
            vb_q    <= (beam_i.v >= vid_pkg::V_VISIBLE);
            if (acc && !bus_rd_nwr_i && bus_reg_num_i == vid_pkg::REG_INT_CTRL && bus_bytesel_i)
                mask <= bus_data_i[vid_pkg::INTR_VBLANK];
            exp_intr <= vb_rise & mask & ~pend;     // only a fresh, unmasked event
            pend     <= (pend | vb_rise) & ~(acc && !bus_rd_nwr_i && !bus_bytesel_i
                        && bus_reg_num_i == vid_pkg::REG_INT_CTRL && bus_data_i[0]);
            status_chk <= acc && bus_rd_nwr_i && !bus_bytesel_i
                          && bus_reg_num_i == vid_pkg::REG_STATUS;
            exp_status <= {3'b000, pend, 2'b00,
                           beam_i.v >= vid_pkg::V_VISIBLE, beam_i.h >= vid_pkg::H_VISIBLE};
        end
    end

    beam_flags: assert property (@(posedge clk) disable iff (reset_i)
        !$past(reset_i) |-> {beam_i.visible, beam_i.hsync, beam_i.vsync, beam_i.h_blank,
                             beam_i.v_blank} == raster_flags(beam_i.h, beam_i.v))
        else begin $error("beam flags wrong at h %0d v %0d", beam_i.h, beam_i.v); fail_cnt++; end

    h_advance: assert property (@(posedge clk) disable iff (reset_i)
        beam_i.h != vid_pkg::H_TOTAL - 1
        |=> beam_i.h == $past(beam_i.h) + 1 && beam_i.v == $past(beam_i.v))
        else begin $error("column did not advance"); fail_cnt++; end

    line_wrap: assert property (@(posedge clk) disable iff (reset_i)
        beam_i.h == vid_pkg::H_TOTAL - 1
        |=> beam_i.h == 0 && beam_i.v == ($past(beam_i.v) + 1) % vid_pkg::V_TOTAL)
        else begin $error("line wrap wrong, v %0d", beam_i.v); fail_cnt++; end

    pf_pixels: assert property (@(posedge clk) disable iff (reset_i)
        pixel_a_i == exp_a && pixel_b_i == exp_b)
        else begin $error("pf pixel %h/%h, model %h/%h", pixel_a_i, pixel_b_i,
                          exp_a, exp_b); fail_cnt++; end

    rgb_model: assert property (@(posedge clk) disable iff (reset_i) rgb_i == exp_rgb)
        else begin $error("rgb_o %h, model %h", rgb_i, exp_rgb); fail_cnt++; end

    sync_delay: assert property (@(posedge clk) disable iff (reset_i)
        {hsync_i, vsync_i, de_i} == sync2)
        else begin $error("sync/de %b, model %b", {hsync_i, vsync_i, de_i}, sync2); fail_cnt++; end

    black_blank: assert property (@(posedge clk) disable iff (reset_i) !de_i |-> rgb_i == '0)
        else begin $error("rgb_o %h outside display enable", rgb_i); fail_cnt++; end

    intr_model: assert property (@(posedge clk) disable iff (reset_i) intr_i == exp_intr)
        else begin $error("bus_intr_o %b, model %b", intr_i, exp_intr); fail_cnt++; end

    intr_pulse: assert property (@(posedge clk) disable iff (reset_i) intr_i |=> !intr_i)
        else begin $error("bus_intr_o high for more than a cycle"); fail_cnt++; end

    status_read: assert property (@(posedge clk) disable iff (reset_i)
        status_chk |-> bus_rdata_i == exp_status)
        else begin $error("STATUS %h, model %h", bus_rdata_i, exp_status); fail_cnt++; end

endmodule

bind vid_main vid_main_assertions chk0 (
    .clk           (clk),
    .reset_i       (reset_i),
    .cfg_i         (cfg),
    .beam_i        (beam),
    .pixel_a_i     (pixel_a),
    .pixel_b_i     (pixel_b),
    .bus_cs_n_i    (bus_cs_n_i),
    .bus_rd_nwr_i  (bus_rd_nwr_i),
    .bus_reg_num_i (bus_reg_num_i),
    .bus_bytesel_i (bus_bytesel_i),
    .bus_data_i    (bus_data_i),
    .bus_rdata_i   (bus_data_o),
    .intr_i        (bus_intr_o),
    .rgb_i         (rgb_o),
    .hsync_i       (hsync_o),
    .vsync_i       (vsync_o),
    .de_i          (dv_de_o)
);

//--- test/tb_vid_main.sv
// testbench for the video display controller
// drives the register bus on the falling clock edge and walks through
// reset, raster timing, register read-back, single playfield, blending
// and the vblank interrupt; pixel, sync and interrupt checks sit in the
// bound checker, read-back bytes are compared here
module tb_vid_main;

    logic           clk;
    logic           reset_i;
    logic           bus_cs_n_i;
    logic           bus_rd_nwr_i;
    logic [3:0]     bus_reg_num_i;
    logic           bus_bytesel_i;
    logic [7:0]     bus_data_i;
    logic [7:0]     bus_data_o;
    logic           bus_intr_o;
    vid_pkg::rgb_t  rgb_o;
    logic           hsync_o;
    logic           vsync_o;
    logic           dv_de_o;
    logic [31:0]    lcg_state;
    int             frame_len = vid_pkg::H_TOTAL * vid_pkg::V_TOTAL;   // cycles per frame

    vid_main dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("TEST FAIL");
        $fatal(1, "%s", why);
    endtask

    // checker errors stop the run on the next falling edge
    always @(negedge clk) begin
        if (dut0.chk0.fail_cnt != 0) abort_run("bound checker reported an assertion failure");
    end

    function automatic logic [7:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];            // upper bits, better spread
    endfunction

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    // one-cycle select pulse, select high again before the next access
    task automatic bus_write(input logic [3:0] num, input logic odd, input logic [7:0] d);
        @(negedge clk);
        bus_cs_n_i    = 1'b0;
        bus_rd_nwr_i  = 1'b0;
        bus_reg_num_i = num;
        bus_bytesel_i = odd;
        bus_data_i    = d;
        @(negedge clk);
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
    endtask

    task automatic bus_read(input logic [3:0] num, input logic odd, output logic [7:0] d);
        @(negedge clk);
        bus_cs_n_i    = 1'b0;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = num;
        bus_bytesel_i = odd;
        @(negedge clk);                     // data registered on the start cycle
        d          = bus_data_o;
        bus_cs_n_i = 1'b1;
    endtask

    // storage bits of each register byte, from the register map
    function automatic logic [7:0] rw_bits(input logic [3:0] num, input logic odd);
        case (num)
            vid_pkg::REG_PFA_COLOR, vid_pkg::REG_PFB_COLOR: return odd ? 8'h0F : 8'hFF;
            vid_pkg::REG_PFA_CTRL, vid_pkg::REG_PFB_CTRL:   return odd ? 8'h00 : 8'hF7;
            vid_pkg::REG_BLEND:                             return odd ? 8'h00 : 8'h01;
            vid_pkg::REG_INT_CTRL:                          return odd ? 8'h0F : 8'h00;
            default:                                        return 8'h00;
        endcase
    endfunction

    // random colour, tile size and alpha; hot sets each channel's top bit
    task automatic set_playfield(input logic is_b, input logic hot);
        logic [3:0] num;
        logic [7:0] r;
        num = is_b ? vid_pkg::REG_PFB_COLOR : vid_pkg::REG_PFA_COLOR;
        r = next_rand();
        bus_write(num, 1'b0, hot ? (r | 8'h88) : r);            // green, blue
        r = next_rand();
        bus_write(num, 1'b1, {4'h0, hot ? (r[3:0] | 4'h8) : r[3:0]});     // red
        r = next_rand();
        bus_write(num + 4'd1, 1'b0, {r[7:4], 1'b0, r[2:1], 1'b1});        // alpha may be 0
    endtask

    task automatic run_frames(input int n);
        repeat (n * frame_len) @(negedge clk);
    endtask

    task automatic wait_intr(input int limit);
        int n;
        n = 0;
        while (bus_intr_o !== 1'b1) begin
            if (n == limit) abort_run("timed out waiting for the vblank interrupt");
            @(negedge clk);
            n++;
        end
    endtask

    initial begin
        logic [7:0] rd;
        logic [7:0] d;
        int         pulses;
        lcg_state     = 32'd74117;
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = '0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_val("bus_intr_o", {15'h0, bus_intr_o}, 16'h0);
        check_val("{hsync_o,vsync_o,dv_de_o}", {13'h0, hsync_o, vsync_o, dv_de_o}, 16'h0);
        check_val("rgb_o", {4'h0, rgb_o}, 16'h0);
        reset_i = 1'b0;

        // every register byte is zero out of reset, well before the first vblank
        for (int r = 0; r <= 5; r++) begin
            for (int b = 0; b < 2; b++) begin
                bus_read(4'(r), b[0], rd);
                check_val("bus_data_o", {8'h0, rd}, 16'h0);
            end
        end

        run_frames(2);                      // both playfields off, raster only

        // read-back, INT_CTRL low byte is pending/clear so it is skipped
        repeat (3) begin
            for (int r = 0; r <= 5; r++) begin
                for (int b = 0; b < 2; b++) begin
                    if (r == 5 && b == 0) continue;
                    d = next_rand();
                    bus_write(4'(r), b[0], d);
                    bus_read(4'(r), b[0], rd);
                    check_val("bus_data_o", {8'h0, rd}, {8'h0, d & rw_bits(4'(r), b[0])});
                end
            end
        end
        bus_read(4'd9, 1'b0, rd);           // unused
        check_val("bus_data_o", {8'h0, rd}, 16'h0);
        repeat (24) begin                   // STATUS at scattered beam positions
            bus_read(vid_pkg::REG_STATUS, 1'b0, rd);
            repeat (next_rand() % 23) @(negedge clk);
        end

        // playfield A alone, every tile size
        bus_write(vid_pkg::REG_PFB_CTRL, 1'b0, 8'h00);
        bus_write(vid_pkg::REG_BLEND, 1'b0, 8'h00);
        for (int t = 0; t < 4; t++) begin
            set_playfield(1'b0, 1'b0);
            d = next_rand();
            bus_write(vid_pkg::REG_PFA_CTRL, 1'b0, {d[7:4] | 4'h1, 1'b0, 2'(t), 1'b1});
            run_frames(1);
        end

        // both playfields, overlay then add-clamp with hot colours
        repeat (3) begin
            set_playfield(1'b0, 1'b0);
            set_playfield(1'b1, 1'b0);
            run_frames(1);
        end
        bus_write(vid_pkg::REG_BLEND, 1'b0, 8'h01);
        repeat (3) begin
            set_playfield(1'b0, 1'b1);
            set_playfield(1'b1, 1'b1);
            run_frames(1);
        end

        // vblank interrupt unmasked, acknowledge each pulse
        bus_write(vid_pkg::REG_INT_CTRL, 1'b1, 8'h01);
        run_frames(1);                      // pending left over from earlier frames, no pulse
        bus_write(vid_pkg::REG_INT_CTRL, 1'b0, 8'h01);      // drop stale pending
        repeat (2) begin
            wait_intr(2 * frame_len);
            bus_write(vid_pkg::REG_INT_CTRL, 1'b0, 8'h01);
            bus_read(vid_pkg::REG_STATUS, 1'b0, rd);
            check_val("bus_data_o[7:4]", {12'h0, rd[7:4]}, 16'h0);
        end

        // masked, a full frame without a pulse but pending still sets
        bus_write(vid_pkg::REG_INT_CTRL, 1'b1, 8'h00);
        bus_write(vid_pkg::REG_INT_CTRL, 1'b0, 8'h01);
        pulses = 0;
        repeat (frame_len + vid_pkg::H_TOTAL) begin
            @(negedge clk);
            if (bus_intr_o) pulses++;
        end
        check_val("bus_intr_o pulses", 16'(pulses), 16'h0);
        bus_read(vid_pkg::REG_STATUS, 1'b0, rd);
        check_val("bus_data_o[4]", {15'h0, rd[4]}, 16'h1);

        run_frames(1);
        if (dut0.chk0.fail_cnt == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("bound checker reported an assertion failure");
        end
    end

endmodule

//--- tb.f
src/vid_pkg.sv
src/vid_timing.sv
src/playfield_gen.sv
src/pf_blend.sv
src/bus_regs.sv
src/vid_main.sv
test/vid_main_assertions.sv
test/tb_vid_main.sv

//--- Bender.yml
package:
  name: vid_main

sources:
  - src/vid_pkg.sv
  - src/vid_timing.sv
  - src/playfield_gen.sv
  - src/pf_blend.sv
  - src/bus_regs.sv
  - src/vid_main.sv
  - target: test
    files:
      - test/vid_main_assertions.sv
      - test/tb_vid_main.sv
